// File: src/cache_mem_pkg.sv
/*
  shared sizes, commands and bus types of the 2-way cache block
  sizes are fixed here, no module takes a parameter
  address offset bits [3:2] pick the word, bits [1:0] the byte
*/
`default_nettype none

package cache_mem_pkg;

  ////////////////////////////////////////
  // sizes
  ////////////////////////////////////////
  localparam int XLEN          = 32;                           // core word
  localparam int PLEN          = 34;                           // physical address
  localparam int BLK_BITS      = 128;                          // one line, 4 words
  localparam int WAYS          = 2;
  localparam int SETS          = 16;
  localparam int IDX_BITS      = $clog2(SETS);                 // 4
  localparam int BLK_OFFS_BITS = $clog2(BLK_BITS / 8);         // byte in line
  localparam int DAT_OFFS_BITS = $clog2(BLK_BITS / XLEN);      // word in line
  localparam int TAG_BITS      = PLEN - IDX_BITS - BLK_OFFS_BITS;

  typedef logic [$clog2(WAYS)-1:0] way_t;   // way number
  typedef logic [WAYS-1:0]         ways_t;  // one-hot way list
  typedef logic [BLK_BITS-1:0]     line_t;

  typedef enum logic [1:0] {
    CMD_READ      = 2'd0,
    CMD_WRITE     = 2'd1,
    CMD_FILL      = 2'd2,
    CMD_INVAL_ALL = 2'd3
  } cmd_e;

  ////////////////////////////////////////
  // address views
  ////////////////////////////////////////
  typedef struct packed {
    logic [TAG_BITS-1:0]      tag;
    logic [IDX_BITS-1:0]      idx;
    logic [BLK_OFFS_BITS-1:0] offs;  // top DAT_OFFS_BITS select the word
  } paddr_fields_t;

  typedef union packed {
    logic [PLEN-1:0] flat;
    paddr_fields_t   f;
  } paddr_u;

  ////////////////////////////////////////
  // request, response and array strobes
  ////////////////////////////////////////
  typedef struct packed {
    cmd_e              cmd;
    paddr_u            adr;
    logic [XLEN/8-1:0] be;          // word write byte enables
    logic [XLEN-1:0]   wdata;
    line_t             fill_line;
    way_t              fill_way;
    logic              fill_dirty;
  } cache_req_t;

  typedef struct packed {
    logic            hit;
    ways_t           ways_hit;
    logic            way_dirty;
    line_t           line;
    logic            evict_valid;
    logic [PLEN-1:0] evict_adr;
  } cache_rsp_t;

  typedef struct packed {
    logic rd;                        // read the set, latch index
    logic wr_fill;
    logic wr_word;
    logic inval_all;
    way_t fill_way;
    logic fill_dirty;
  } arr_ctl_t;

endpackage

`default_nettype wire

// File: src/cache_tag_array.sv
/*
  per-way tags with valid and dirty flops, hit compare on the read set
  compare outputs follow the index latched by the last rd strobe
  writes use the request index, which equals the latched one in sequence
*/
`timescale 1ns/100ps
`default_nettype none

module cache_tag_array
  import cache_mem_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  arr_ctl_t                      ctl_i,
  input  paddr_u                        adr_i,
  output ways_t                         ways_hit_o,
  output ways_t                         valid_o,
  output ways_t                         dirty_o,
  output logic [WAYS-1:0][TAG_BITS-1:0] tags_o
);

  logic [IDX_BITS-1:0] rd_idx_q;  // set being compared

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rd_idx_q <= '0;
    else if (ctl_i.rd)
      rd_idx_q <= adr_i.f.idx;
  end

  ////////////////////////////////////////
  // ways
  ////////////////////////////////////////
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    logic [TAG_BITS-1:0] tag_mem_q [SETS];
    logic [SETS-1:0]     valid_q;
    logic [SETS-1:0]     dirty_q;
    logic                fill_sel;   // fill targets this way
    logic                word_sel;   // word write hits this way

    assign fill_sel = ctl_i.wr_fill & (ctl_i.fill_way == way_t'(w));
    assign word_sel = ctl_i.wr_word & ways_hit_o[w];

    // tag storage, only written by a fill
    always_ff @(posedge clk_i)
    begin
      if (fill_sel) tag_mem_q[adr_i.f.idx] <= adr_i.f.tag;
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        valid_q <= '0;
      else if (ctl_i.inval_all)
        valid_q <= '0;                      // whole cache at once
      else if (fill_sel)
        valid_q[adr_i.f.idx] <= 1'b1;
    end

    always_ff @(posedge clk_i or negedge rst_ni)
    begin
      if (!rst_ni)
        dirty_q <= '0;
      else if (fill_sel)
        dirty_q[adr_i.f.idx] <= ctl_i.fill_dirty;
      else if (word_sel)
        dirty_q[adr_i.f.idx] <= 1'b1;       // core wrote the line
    end

    // read side
    assign tags_o[w]     = tag_mem_q[rd_idx_q];
    assign valid_o[w]    = valid_q[rd_idx_q];
    assign dirty_o[w]    = dirty_q[rd_idx_q];
    assign ways_hit_o[w] = valid_o[w] & (tags_o[w] == adr_i.f.tag);
  end

endmodule

`default_nettype wire

// File: src/cache_data_array.sv
/*
  per-way line storage, registered read on rd
  word writes go to the hit ways only, fills to the chosen way
*/
`timescale 1ns/100ps
`default_nettype none

module cache_data_array
  import cache_mem_pkg::*;
(
  input  logic              clk_i,
  input  arr_ctl_t          ctl_i,
  input  paddr_u            adr_i,
  input  logic [XLEN/8-1:0] be_i,
  input  logic [XLEN-1:0]   wdata_i,
  input  line_t             fill_line_i,
  input  ways_t             ways_hit_i,
  output line_t [WAYS-1:0]  lines_o
);

  line_t                     wdata_line;  // word copied over the line
  logic [BLK_BITS/8-1:0]     line_be;     // byte enables across the line
  logic [DAT_OFFS_BITS-1:0]  word_sel;

  assign word_sel   = adr_i.f.offs[BLK_OFFS_BITS-1 -: DAT_OFFS_BITS];
  assign wdata_line = {(BLK_BITS/XLEN){wdata_i}};

  // only the addressed word gets enables
  always_comb
  begin
    for (int b = 0; b < BLK_BITS/8; b++)
      line_be[b] = (word_sel == DAT_OFFS_BITS'(b / (XLEN/8))) & be_i[b % (XLEN/8)];
  end

  ////////////////////////////////////////
  // ways
  ////////////////////////////////////////
  for (genvar w = 0; w < WAYS; w++)
  begin : gen_way
    line_t mem_q [SETS];
    line_t rd_line_q;
    logic  fill_sel;

    assign fill_sel = ctl_i.wr_fill & (ctl_i.fill_way == way_t'(w));

    always_ff @(posedge clk_i)
    begin
      if (fill_sel)
        mem_q[adr_i.f.idx] <= fill_line_i;  // whole line
      else if (ctl_i.wr_word && ways_hit_i[w])
      begin
        for (int b = 0; b < BLK_BITS/8; b++)
          if (line_be[b]) mem_q[adr_i.f.idx][b*8 +: 8] <= wdata_line[b*8 +: 8];
      end
      if (ctl_i.rd) rd_line_q <= mem_q[adr_i.f.idx];
    end

    assign lines_o[w] = rd_line_q;
  end

endmodule

`default_nettype wire

// File: src/cache_resp_stage.sv
/*
  builds and holds the response until it is taken
  a write answers with hit state and line from before the write
  a fill answers with hit fields zero, old line zero if it was invalid
  evict_adr is zero unless evict_valid is set
*/
`timescale 1ns/100ps
`default_nettype none

module cache_resp_stage
  import cache_mem_pkg::*;
(
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          capture_i,
  input  logic                          rsp_fire_i,
  input  cmd_e                          cmd_i,
  input  paddr_u                        adr_i,
  input  way_t                          fill_way_i,
  input  ways_t                         ways_hit_i,
  input  ways_t                         valid_i,
  input  ways_t                         dirty_i,
  input  logic [WAYS-1:0][TAG_BITS-1:0] tags_i,
  input  line_t [WAYS-1:0]              lines_i,
  output cache_rsp_t                    rsp_o
);

  line_t      hit_line;
  logic       old_dirty;   // fill victim needs write back
  paddr_u     evict_adr;
  cache_rsp_t rsp_d, rsp_q;

  // and/or mux, at most one way hits
  always_comb
  begin
    hit_line = '0;
    for (int w = 0; w < WAYS; w++)
      hit_line |= lines_i[w] & {BLK_BITS{ways_hit_i[w]}};
  end

  assign old_dirty = valid_i[fill_way_i] & dirty_i[fill_way_i];

  ////////////////////////////////////////
  // next response
  ////////////////////////////////////////
  always_comb
  begin
    rsp_d          = '0;
    evict_adr.flat = '0;                      // offset stays zero
    case (cmd_i)
      CMD_READ, CMD_WRITE:
      begin
        rsp_d.hit       = |ways_hit_i;
        rsp_d.ways_hit  = ways_hit_i;
        rsp_d.way_dirty = |(ways_hit_i & dirty_i);
        rsp_d.line      = hit_line;
      end
      CMD_FILL:
      begin
        rsp_d.line        = valid_i[fill_way_i] ? lines_i[fill_way_i] : '0;
        rsp_d.evict_valid = old_dirty;
        if (old_dirty)
        begin
          evict_adr.f.tag = tags_i[fill_way_i];  // victim tag, same set
          evict_adr.f.idx = adr_i.f.idx;
        end
        rsp_d.evict_adr = evict_adr.flat;
      end
      default: ;                              // invalidate answers all zero
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rsp_q <= '0;
    else if (capture_i)
      rsp_q <= rsp_d;
    else if (rsp_fire_i)
      rsp_q <= '0;   // taken
  end

  assign rsp_o = rsp_q;

endmodule

`default_nettype wire

// File: src/cache_seq_fsm.sv
/*
  accepts one request at a time, steps the arrays, holds the response
  LOOKUP lasts two cycles: array read, then compare and capture
*/
`timescale 1ns/100ps
`default_nettype none

module cache_seq_fsm
  import cache_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i,
  input  cache_req_t req_i,
  output logic       req_ready_o,
  input  logic       rsp_ready_i,
  output logic       rsp_valid_o,
  output cache_req_t req_q_o,
  output arr_ctl_t   arr_ctl_o,
  input  logic       hit_i,
  output logic       capture_o,
  output logic       rsp_fire_o
);

  typedef enum logic [1:0] {IDLE, LOOKUP, UPDATE, RESPOND} state_e;

  state_e     state_q, state_d;
  logic       rd_done_q;       // second lookup cycle
  cache_req_t req_q;
  logic       req_fire;
  logic       is_inval;
  logic       needs_update;    // write or fill

  assign req_fire     = req_valid_i & req_ready_o;
  assign is_inval     = (req_q.cmd == CMD_INVAL_ALL);
  assign needs_update = (req_q.cmd == CMD_WRITE) | (req_q.cmd == CMD_FILL);

  ////////////////////////////////////////
  // state
  ////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q   <= IDLE;
      rd_done_q <= 1'b0;
    end
    else
    begin
      state_q   <= state_d;
      rd_done_q <= (state_q == LOOKUP) & ~rd_done_q;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (req_fire) req_q <= req_i;  // held until next accept
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (req_fire) state_d = LOOKUP;
      LOOKUP:
      begin
        if (rd_done_q) state_d = needs_update ? UPDATE : RESPOND;
      end
      UPDATE:  state_d = RESPOND;              // single write cycle
      RESPOND: if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  ////////////////////////////////////////
  // array strobes
  ////////////////////////////////////////
  always_comb
  begin
    arr_ctl_o            = '0;
    arr_ctl_o.fill_way   = req_q.fill_way;
    arr_ctl_o.fill_dirty = req_q.fill_dirty;
    if (state_q == LOOKUP && !rd_done_q)
    begin
      arr_ctl_o.rd        = ~is_inval;
      arr_ctl_o.inval_all = is_inval;
    end
    if (state_q == UPDATE)
    begin
      arr_ctl_o.wr_word = (req_q.cmd == CMD_WRITE) & hit_i;  // write miss leaves arrays alone
      arr_ctl_o.wr_fill = (req_q.cmd == CMD_FILL);
    end
  end

  assign capture_o   = (state_q == LOOKUP) & rd_done_q;  // compare result valid here
  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_fire_o  = rsp_valid_o & rsp_ready_i;
  assign req_q_o     = req_q;

endmodule

`default_nettype wire

// File: src/cache_mem_top.sv
/*
  2-way set associative cache memory, one command in flight
  read and invalidate answer 2 cycles after accept, write and fill 3
*/
`timescale 1ns/100ps
`default_nettype none

module cache_mem_top
  import cache_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       req_valid_i,
  input  cache_req_t req_i,
  output logic       req_ready_o,
  output logic       rsp_valid_o,
  output cache_rsp_t rsp_o,
  input  logic       rsp_ready_i
);

  cache_req_t                  req_q;     // accepted request
  arr_ctl_t                    arr_ctl;
  ways_t                       ways_hit;
  ways_t                       valid;     // read set, per way
  ways_t                       dirty;
  logic [WAYS-1:0][TAG_BITS-1:0] tags;
  line_t [WAYS-1:0]            lines;
  logic                        capture;
  logic                        rsp_fire;

  ////////////////////////////////////////
  // command sequencer
  ////////////////////////////////////////
  cache_seq_fsm i_seq (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .req_valid_i ( req_valid_i ),
    .req_i       ( req_i       ),
    .req_ready_o ( req_ready_o ),
    .rsp_ready_i ( rsp_ready_i ),
    .rsp_valid_o ( rsp_valid_o ),
    .req_q_o     ( req_q       ),
    .arr_ctl_o   ( arr_ctl     ),
    .hit_i       ( |ways_hit   ),  // any way hits
    .capture_o   ( capture     ),
    .rsp_fire_o  ( rsp_fire    )
  );

  ////////////////////////////////////////
  // arrays
  ////////////////////////////////////////
  cache_tag_array i_tag (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .ctl_i      ( arr_ctl   ),
    .adr_i      ( req_q.adr ),
    .ways_hit_o ( ways_hit  ),
    .valid_o    ( valid     ),
    .dirty_o    ( dirty     ),
    .tags_o     ( tags      )
  );

  cache_data_array i_data (
    .clk_i       ( clk_i           ),
    .ctl_i       ( arr_ctl         ),
    .adr_i       ( req_q.adr       ),
    .be_i        ( req_q.be        ),
    .wdata_i     ( req_q.wdata     ),
    .fill_line_i ( req_q.fill_line ),
    .ways_hit_i  ( ways_hit        ),
    .lines_o     ( lines           )
  );

  cache_resp_stage i_rsp (
    .clk_i      ( clk_i          ),
    .rst_ni     ( rst_ni         ),
    .capture_i  ( capture        ),
    .rsp_fire_i ( rsp_fire       ),
    .cmd_i      ( req_q.cmd      ),
    .adr_i      ( req_q.adr      ),
    .fill_way_i ( req_q.fill_way ),
    .ways_hit_i ( ways_hit       ),
    .valid_i    ( valid          ),
    .dirty_i    ( dirty          ),
    .tags_i     ( tags           ),
    .lines_i    ( lines          ),
    .rsp_o      ( rsp_o          )
  );

endmodule

`default_nettype wire

// File: bench/tb_clock_gen.sv
/*
  bench clock and reset, 10 ns period
  reset held low for 16 rising edges, released on a falling edge
*/
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  initial
  begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;      // 10 ns period
  end

  initial
  begin
    rst_no = 1'b0;
    repeat (16) @(posedge clk_o);
    @(negedge clk_o);               // release away from the active edge
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tb_cache_mem.sv
/*
  runs the vectors of bench/cache_testdata.txt through the cache, one per command
  inputs move on the falling edge, outputs are sampled there too
  stops at the first wrong value
*/
`timescale 1ns/100ps
`default_nettype none

module tb_cache_mem
  import cache_mem_pkg::*;
();

  localparam int         FIELDS        = 14;     // words per vector
  localparam int         MAX_VEC       = 32;
  localparam int         READY_TIMEOUT = 20;     // cycles
  localparam int         RSP_TIMEOUT   = 20;
  localparam int         RESET_TIMEOUT = 40;
  localparam logic [7:0] END_ID        = 8'hff;  // list terminator

  logic         clk;
  logic         rst_n;
  logic         req_valid;
  cache_req_t   req;
  logic         req_ready;
  logic         rsp_valid;
  cache_rsp_t   rsp;
  logic         rsp_ready;
  logic [127:0] vec_mem [FIELDS*MAX_VEC];
  logic [15:0]  lfsr_q;                          // back-pressure source
  int           n_run;

  tb_clock_gen i_clk_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  cache_mem_top i_cache_mem_top (
    .clk_i       ( clk       ),
    .rst_ni      ( rst_n     ),
    .req_valid_i ( req_valid ),
    .req_i       ( req       ),
    .req_ready_o ( req_ready ),
    .rsp_valid_o ( rsp_valid ),
    .rsp_o       ( rsp       ),
    .rsp_ready_i ( rsp_ready )
  );

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic string cmd_label(input cmd_e c);
    case (c)
      CMD_READ:  return "read";
      CMD_WRITE: return "write";
      CMD_FILL:  return "fill";
      default:   return "inval";
    endcase
  endfunction

  task automatic draw_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);               // one step per bit
      val    = (val << 1) | int'(lfsr_q[0]);
    end
  endtask

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_field(input string test, input string field,
                             input logic [127:0] exp, input logic [127:0] act);
    assert (act === exp)
    else fail_run($sformatf("MISMATCH %s %s expected %0h actual %0h", test, field, exp, act));
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else fail_run(what);
  endtask

  ////////////////////////////////////////
  // waits, each with its own limit
  ////////////////////////////////////////
  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) fail_run("reset was never released");
    end
  endtask

  task automatic wait_req_ready(input string test);
    int cycles;
    cycles = 0;
    while (req_ready !== 1'b1)
    begin
      @(negedge clk);
      cycles++;
      if (cycles > READY_TIMEOUT) fail_run($sformatf("%s: req_ready never rose", test));
    end
  endtask

  task automatic wait_rsp_valid(input string test, output int cycles);
    cycles = 0;
    while (rsp_valid !== 1'b1)
    begin
      check_true(req_ready === 1'b0, $sformatf("%s: req_ready high while busy", test));
      @(negedge clk);
      cycles++;
      if (cycles > RSP_TIMEOUT) fail_run($sformatf("%s: no response arrived", test));
    end
  endtask

  ////////////////////////////////////////
  // one vector
  ////////////////////////////////////////
  task automatic load_request(input int base, output cache_req_t rq);
    rq            = '0;
    rq.cmd        = cmd_e'(vec_mem[base+1][1:0]);
    rq.adr.flat   = vec_mem[base+2][PLEN-1:0];
    rq.be         = vec_mem[base+3][XLEN/8-1:0];
    rq.wdata      = vec_mem[base+4][XLEN-1:0];
    rq.fill_way   = way_t'(vec_mem[base+5][0]);
    rq.fill_dirty = vec_mem[base+6][0];
    rq.fill_line  = vec_mem[base+7];
  endtask

  task automatic run_vector(input int v);
    int         base;
    int         lat;
    int         exp_lat;
    int         hold;
    string      test;
    cache_req_t rq;
    cache_rsp_t held;
    base = v * FIELDS;
    load_request(base, rq);
    test = $sformatf("b%0d_v%0d_%s", vec_mem[base][7:0], v, cmd_label(rq.cmd));
    wait_req_ready(test);
    req_valid = 1'b1;
    req       = rq;
    @(negedge clk);                               // taken on the edge before
    req_valid = 1'b0;
    req       = '0;                               // DUT must use its own copy
    wait_rsp_valid(test, lat);
    exp_lat = (rq.cmd == CMD_READ || rq.cmd == CMD_INVAL_ALL) ? 2 : 3;
    check_field(test, "latency", 128'(exp_lat), 128'(lat));
    // stall the response a random 0..3 cycles
    held = rsp;
    draw_bits(2, hold);
    repeat (hold)
    begin
      @(negedge clk);
      check_true(rsp_valid === 1'b1 && rsp === held && req_ready === 1'b0,
                 $sformatf("%s: response moved or req_ready rose while stalled", test));
    end
    check_field(test, "hit",         vec_mem[base+8],  128'(rsp.hit));
    check_field(test, "ways_hit",    vec_mem[base+9],  128'(rsp.ways_hit));
    check_field(test, "way_dirty",   vec_mem[base+10], 128'(rsp.way_dirty));
    check_field(test, "evict_valid", vec_mem[base+11], 128'(rsp.evict_valid));
    check_field(test, "evict_adr",   vec_mem[base+12], 128'(rsp.evict_adr));
    check_field(test, "line",        vec_mem[base+13], 128'(rsp.line));
    rsp_ready = 1'b1;
    @(negedge clk);
    rsp_ready = 1'b0;
    check_true(rsp_valid === 1'b0 && rsp === '0,
               $sformatf("%s: response not cleared after it was taken", test));
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////
  initial
  begin
    int v;
    bit done;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    lfsr_q    = 16'd26;
    n_run     = 0;
    v         = 0;
    done      = 1'b0;
    $readmemh("bench/cache_testdata.txt", vec_mem);
    wait_reset();
    check_true(req_ready === 1'b1 && rsp_valid === 1'b0, "wrong handshake state after reset");
    while (!done)
    begin
      if (v >= MAX_VEC)
        fail_run("testdata has more vectors than the bench holds");
      else if (vec_mem[v*FIELDS][7:0] == END_ID)
        done = 1'b1;
      else if ($isunknown(vec_mem[v*FIELDS]) || vec_mem[v*FIELDS] == '0)
        fail_run("testdata ends without its end marker");
      else
      begin
        run_vector(v);
        v++;
        n_run++;
      end
    end
    if (n_run > 0)
    begin
      $display("TB PASSED");
      $finish;
    end
    else
      fail_run("testdata holds no vectors");
  end

endmodule

`default_nettype wire

// File: bench/cache_testdata.txt
// line a: id cmd adr be wdata fill_way fill_dirty fill_line
// line b: exp hit ways_hit way_dirty evict_valid evict_adr line
// cmd 0 read 1 write 2 fill 3 inval_all, id ff ends the list
1 0 001234550 0 0 0 0 0
0 0 0 0 0 0
2 2 001234550 0 0 0 0 00112233445566778899aabbccddeeff
0 0 0 0 0 0
2 2 00abcde50 0 0 1 1 0f1e2d3c4b5a69788796a5b4c3d2e1f0
0 0 0 0 0 0
2 0 001234554 0 0 0 0 0
1 1 0 0 0 00112233445566778899aabbccddeeff
2 0 00abcde50 0 0 0 0 0
1 2 1 0 0 0f1e2d3c4b5a69788796a5b4c3d2e1f0
3 1 001234558 5 deadbeef 0 0 0
1 1 0 0 0 00112233445566778899aabbccddeeff
3 0 001234550 0 0 0 0 0
1 1 1 0 0 0011223344ad66ef8899aabbccddeeff
3 1 000077750 f 12345678 0 0 0
0 0 0 0 0 0
4 2 000077750 0 0 0 0 11111111222222223333333344444444
0 0 0 1 001234550 0011223344ad66ef8899aabbccddeeff
4 2 155555550 0 0 0 0 a5a5a5a55a5a5a5a00000000ffffffff
0 0 0 0 0 11111111222222223333333344444444
4 0 15555555c 0 0 0 0 0
1 1 0 0 0 a5a5a5a55a5a5a5a00000000ffffffff
5 3 0 0 0 0 0 0
0 0 0 0 0 0
5 0 00abcde50 0 0 0 0 0
0 0 0 0 0 0
5 0 155555550 0 0 0 0 0
0 0 0 0 0 0
4 2 000012350 0 0 1 0 000000000000000000000000cafef00d
0 0 0 0 0 0
6 0 000012350 0 0 0 0 0
1 2 0 0 0 000000000000000000000000cafef00d
ff

// File: list.f
src/cache_mem_pkg.sv
src/cache_tag_array.sv
src/cache_data_array.sv
src/cache_resp_stage.sv
src/cache_seq_fsm.sv
src/cache_mem_top.sv
bench/tb_clock_gen.sv
bench/tb_cache_mem.sv

// File: Makefile
# Verilator build and run of the cache memory testbench

VERILATOR  ?= verilator
TOP        ?= tb_cache_mem
RTL_TOP    ?= cache_mem_top
FILELIST   ?= list.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
